// ==== Makefile ====
TOP = input_arbiter_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -f verilog.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -Wall -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// ==== logic/arbiter_fsm.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin packet arbiter FSM
// Locks onto one queue per packet, drives read strobes and output mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module arbiter_fsm
   import input_arbiter_pkg::*;
(
   input  logic                         axi_aclk,
   input  logic                         axi_resetn,

   // Queue heads
   input  axis_beat_t [num_queues-1:0]  q_beat,
   input  logic       [num_queues-1:0]  q_empty,
   output logic       [num_queues-1:0]  rd_en,

   // Output stream
   output axis_beat_t                   m_beat,
   output logic                         m_valid,
   input  logic                         m_ready,

   // Packet completion to the counters
   output logic                         pkt_done,
   output queue_idx_t                   done_queue
);

   arb_state_t state;
   arb_state_t state_next;

   queue_idx_t cur_queue;
   queue_idx_t cur_queue_next;
   queue_idx_t cur_queue_plus1;

   logic xfer;   // Beat leaves on this edge

   // Next port in cyclic order
   assign cur_queue_plus1 = (cur_queue == queue_idx_t'(num_queues - 1)) ?
                            '0 : cur_queue + queue_idx_t'(1);

   // Selected queue straight onto the output
   assign m_beat  = q_beat[cur_queue];
   assign m_valid = ~q_empty[cur_queue];   // Only a stored beat is ever offered
   assign xfer    = m_valid & m_ready;

   // Completion pulse, lasts the single cycle of the last transfer
   assign pkt_done   = xfer & m_beat.tlast;
   assign done_queue = cur_queue;

   always_comb begin
      state_next     = state;
      cur_queue_next = cur_queue;
      rd_en          = '0;

      case (state)
         idle: begin
            if (q_empty[cur_queue]) begin
               cur_queue_next = cur_queue_plus1;    // Nothing here, try next port
            end else if (xfer) begin
               rd_en[cur_queue] = 1'b1;
               if (m_beat.tlast) begin
                  cur_queue_next = cur_queue_plus1; // Single-beat packet done
               end else begin
                  state_next = wr_pkt;
               end
            end
         end

         wr_pkt: begin
            // Stay on this queue, even if it runs dry mid-packet
            if (xfer) begin
               rd_en[cur_queue] = 1'b1;
               if (m_beat.tlast) begin
                  state_next     = idle;
                  cur_queue_next = cur_queue_plus1;
               end
            end
         end

         default: begin
            state_next = idle;
         end
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state     <= idle;
         cur_queue <= '0;
      end else begin
         state     <= state_next;
         cur_queue <= cur_queue_next;
      end
   end

endmodule

// ==== logic/fallthrough_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// First-word-fallthrough queue for one receive port
// Head beat always visible at dout, nearly-full flag for flow control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fallthrough_fifo
   import input_arbiter_pkg::*;
(
   input  logic       axi_aclk,
   input  logic       axi_resetn,

   // Write side
   input  axis_beat_t din,
   input  logic       wr_en,

   // Read side
   input  logic       rd_en,
   output axis_beat_t dout,      // Head entry, valid while empty is low
   output logic       empty,
   output logic       nearly_full
);

   // Storage
   axis_beat_t mem [fifo_depth];

   logic [fifo_depth_bits-1:0] wr_ptr;
   logic [fifo_depth_bits-1:0] rd_ptr;
   logic [fifo_depth_bits:0]   depth_cnt;   // Needs one extra bit for full count

   logic wr_ok;
   logic rd_ok;

   // Drop writes once nearly full, ignore reads when empty
   assign wr_ok = wr_en & ~nearly_full;
   assign rd_ok = rd_en & ~empty;

   // Flags from the occupancy count
   assign empty       = (depth_cnt == '0);
   assign nearly_full = (depth_cnt >= (fifo_depth_bits+1)'(fifo_depth - 1));

   // Fallthrough read, no output register
   assign dout = mem[rd_ptr];

   // Data array
   always_ff @(posedge axi_aclk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= din;
      end
   end

   // Pointers wrap on their own, depth is a power of two
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Occupancy
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         depth_cnt <= '0;
      end else begin
         case ({wr_ok, rd_ok})
            2'b10:   depth_cnt <= depth_cnt + 1'b1;   // Write only
            2'b01:   depth_cnt <= depth_cnt - 1'b1;   // Read only
            default: depth_cnt <= depth_cnt;          // Both or neither
         endcase
      end
   end

endmodule

// ==== logic/input_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-port packet input arbiter
// Per-port queues, round-robin packet selection, per-port statistics
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module input_arbiter
   import input_arbiter_pkg::*;
(
   input  logic                                    axi_aclk,
   input  logic                                    axi_resetn,

   // Receive ports
   input  axis_beat_t [num_queues-1:0]             s_beat,
   input  logic       [num_queues-1:0]             s_valid,
   output logic       [num_queues-1:0]             s_ready,

   // Merged output stream
   output axis_beat_t                              m_beat,
   output logic                                    m_valid,
   input  logic                                    m_ready,

   // Packets forwarded per source port
   output logic [num_queues-1:0][count_width-1:0]  pkt_count
);

   // Queue to arbiter
   axis_beat_t [num_queues-1:0] q_beat;
   logic       [num_queues-1:0] q_empty;
   logic       [num_queues-1:0] q_nearly_full;
   logic       [num_queues-1:0] rd_en;

   // Arbiter to counters
   logic       pkt_done;
   queue_idx_t done_queue;

   // Back-pressure to senders
   assign s_ready = ~q_nearly_full;

   for (genvar i = 0; i < num_queues; i++) begin : g_rx_queue
      fallthrough_fifo u_fifo (
         .axi_aclk    (axi_aclk),
         .axi_resetn  (axi_resetn),
         .din         (s_beat[i]),
         .wr_en       (s_valid[i] & s_ready[i]),   // Accept only on handshake
         .rd_en       (rd_en[i]),
         .dout        (q_beat[i]),
         .empty       (q_empty[i]),
         .nearly_full (q_nearly_full[i])
      );
   end

   // Packet selection
   arbiter_fsm u_arbiter_fsm (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .q_beat     (q_beat),
      .q_empty    (q_empty),
      .rd_en      (rd_en),
      .m_beat     (m_beat),
      .m_valid    (m_valid),
      .m_ready    (m_ready),
      .pkt_done   (pkt_done),
      .done_queue (done_queue)
   );

   // Statistics
   pkt_counter u_pkt_counter (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .pkt_done   (pkt_done),
      .done_queue (done_queue),
      .pkt_count  (pkt_count)
   );

endmodule

// ==== logic/input_arbiter_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Input arbiter package
// Widths, queue depth, beat struct and arbiter state type
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package input_arbiter_pkg;

   // Port count and index width
   localparam int num_queues     = 4;
   localparam int queue_idx_bits = 2;     // log2 of num_queues

   // Stream beat fields
   localparam int data_width  = 64;
   localparam int strb_width  = data_width / 8;  // One strobe per byte
   localparam int tuser_width = 16;

   // Receive queue sizing
   localparam int fifo_depth_bits = 3;
   localparam int fifo_depth      = 1 << fifo_depth_bits;  // 8 entries

   // Per-port forwarded packet counters
   localparam int count_width = 16;

   // One beat as stored in a queue and sent on the output stream
   typedef struct packed {
      logic [data_width-1:0]  tdata;
      logic [strb_width-1:0]  tstrb;
      logic [tuser_width-1:0] tuser;   // Source port and sequence metadata
      logic                   tlast;   // End of packet
   } axis_beat_t;

   // Arbiter states
   typedef enum logic {
      idle   = 1'b0,   // Scanning queues for a packet
      wr_pkt = 1'b1    // Forwarding a packet, locked to one queue
   } arb_state_t;

   // Receive port index
   typedef logic [queue_idx_bits-1:0] queue_idx_t;

endpackage

// ==== logic/pkt_counter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Forwarded packet counters, one per source port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module pkt_counter
   import input_arbiter_pkg::*;
(
   input  logic                                    axi_aclk,
   input  logic                                    axi_resetn,

   // Completion from the arbiter
   input  logic                                    pkt_done,
   input  queue_idx_t                              done_queue,

   // Statistics levels
   output logic [num_queues-1:0][count_width-1:0]  pkt_count
);

   logic at_max;   // Selected counter already saturated

   assign at_max = (pkt_count[done_queue] == {count_width{1'b1}});

   // Only the source port of the finished packet moves
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         pkt_count <= '0;
      end else if (pkt_done && !at_max) begin
         pkt_count[done_queue] <= pkt_count[done_queue] + 1'b1;
      end
   end

endmodule

// ==== verification/arbiter_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Input arbiter monitor
// Rebuilds expected per-port packets and counts, compares DUT outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module arbiter_checker
   import input_arbiter_pkg::*;
(
   input  logic                                   axi_aclk,
   input  logic                                   axi_resetn,
   input  axis_beat_t [num_queues-1:0]            s_beat,
   input  logic       [num_queues-1:0]            s_valid,
   input  logic       [num_queues-1:0]            s_ready,
   input  axis_beat_t                             m_beat,
   input  logic                                   m_valid,
   input  logic                                   m_ready,
   input  logic [num_queues-1:0][count_width-1:0] pkt_count,
   input  logic                                   rr_check,
   input  logic                                   count_check,
   output int                                     outstanding,   // Beats accepted, not yet out
   output int                                     error_count,
   output int                                     check_count
);
   timeunit 1ns;
   timeprecision 1ps;

   axis_beat_t exp_q [num_queues][$];   // Accepted beats per port
   int         seen_last [num_queues];  // Packets seen leaving per port

   logic                   in_pkt;      // Between first beat and tlast
   logic [tuser_width-1:0] cur_tuser;
   logic                   rr_valid;    // rr_expect holds a prediction
   queue_idx_t             rr_expect;

   task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("[ERROR] %0t %s exp %h got %h", $time, name, exp, got);
      end
   endtask

   // Inputs move 1 ns after the rising edge, so the falling edge sees
   // exactly what the next rising edge will capture
   always @(negedge axi_aclk) begin
      axis_beat_t exp_beat;
      queue_idx_t src;
      queue_idx_t nxt;
      int         total;
      if (!axi_resetn) begin
         for (int p = 0; p < num_queues; p++) begin
            exp_q[p].delete();
            seen_last[p] = 0;
         end
         in_pkt      = 1'b0;
         rr_valid    = 1'b0;
         outstanding = 0;
         error_count = 0;
         check_count = 0;
      end else begin
         if (!rr_check) rr_valid = 1'b0;

         // Ready drops at occupancy depth-1
         for (int p = 0; p < num_queues; p++) begin
            check_value($sformatf("s_ready[%0d]", p), 64'(s_ready[p]),
                        64'(exp_q[p].size() < fifo_depth - 1));
         end

         if (m_valid && outstanding == 0) begin
            check_value("m_valid", 64'(m_valid), 64'(0));   // Nothing stored to offer
         end

         if (m_valid && m_ready) begin
            src = m_beat.tuser[tuser_width-1 -: queue_idx_bits];   // Port in top bits
            if (in_pkt) begin
               check_value("m_beat.tuser", 64'(m_beat.tuser), 64'(cur_tuser));   // Interleave
            end else if (rr_valid) begin
               check_value("m_beat.tuser port", 64'(src), 64'(rr_expect));
            end
            if (exp_q[src].size() == 0) begin
               error_count++;
               $display("Output beat claims port %0d but nothing is pending there", src);
            end else begin
               exp_beat = exp_q[src].pop_front();
               check_value("m_beat.tdata", m_beat.tdata, exp_beat.tdata);
               check_value("m_beat.tstrb", 64'(m_beat.tstrb), 64'(exp_beat.tstrb));
               check_value("m_beat.tuser", 64'(m_beat.tuser), 64'(exp_beat.tuser));
               check_value("m_beat.tlast", 64'(m_beat.tlast), 64'(exp_beat.tlast));
            end
            if (m_beat.tlast) begin
               seen_last[src]++;
               in_pkt   = 1'b0;
               rr_valid = 1'b0;
               // Next source is the first port after src with a pending packet
               for (int k = 1; k <= num_queues; k++) begin
                  nxt = queue_idx_t'(int'(src) + k);
                  if (!rr_valid && rr_check && exp_q[nxt].size() != 0) begin
                     rr_expect = nxt;
                     rr_valid  = 1'b1;
                  end
               end
            end else begin
               in_pkt    = 1'b1;
               cur_tuser = m_beat.tuser;
            end
         end

         // Beats the DUT takes on the coming edge
         for (int p = 0; p < num_queues; p++) begin
            if (s_valid[p] && s_ready[p]) exp_q[p].push_back(s_beat[p]);
         end

         if (count_check) begin
            for (int p = 0; p < num_queues; p++) begin
               check_value($sformatf("pkt_count[%0d]", p), 64'(pkt_count[p]),
                           64'(seen_last[p]));
            end
         end

         total = 0;
         for (int p = 0; p < num_queues; p++) total += exp_q[p].size();
         outstanding = total;
      end
   end

endmodule

// ==== verification/input_arbiter_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Input arbiter testbench
// Packet table driver, output back-pressure and run summary
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module input_arbiter_tb
   import input_arbiter_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   // One row of the stimulus table
   typedef struct packed {
      logic [1:0] phase;   // 0 sweep, 1 preload, 2 burst
      queue_idx_t port;
      logic [2:0] len;     // Beats, 1 to 6
   } pkt_row_t;

   localparam int num_rows = 23;

   pkt_row_t rows [num_rows] = '{
      // Sweep with the sink always ready
      '{2'd0, 2'd0, 3'd1}, '{2'd0, 2'd1, 3'd2}, '{2'd0, 2'd2, 3'd3}, '{2'd0, 2'd3, 3'd4},
      '{2'd0, 2'd0, 3'd5}, '{2'd0, 2'd1, 3'd6}, '{2'd0, 2'd2, 3'd6}, '{2'd0, 2'd3, 3'd1},
      // Preload two packets per port, at most 7 beats each port
      '{2'd1, 2'd0, 3'd3}, '{2'd1, 2'd1, 3'd2}, '{2'd1, 2'd2, 3'd4}, '{2'd1, 2'd3, 3'd1},
      '{2'd1, 2'd0, 3'd4}, '{2'd1, 2'd1, 3'd5}, '{2'd1, 2'd2, 3'd2}, '{2'd1, 2'd3, 3'd6},
      // Long burst on port 2, then a few others
      '{2'd2, 2'd2, 3'd6}, '{2'd2, 2'd2, 3'd5}, '{2'd2, 2'd2, 3'd6}, '{2'd2, 2'd2, 3'd4},
      '{2'd2, 2'd2, 3'd6}, '{2'd2, 2'd1, 3'd3}, '{2'd2, 2'd3, 3'd2}
   };

   logic                                   axi_aclk = 1'b0;
   logic                                   axi_resetn;
   axis_beat_t [num_queues-1:0]            s_beat;
   logic       [num_queues-1:0]            s_valid;
   logic       [num_queues-1:0]            s_ready;
   axis_beat_t                             m_beat;
   logic                                   m_valid;
   logic                                   m_ready = 1'b0;
   logic [num_queues-1:0][count_width-1:0] pkt_count;

   logic rr_check;      // Round-robin order checked while high
   logic count_check;   // One-cycle request to compare counters
   int   outstanding;
   int   error_count;
   int   check_count;
   int   tb_errors    = 0;
   int   stall_cycles = 0;    // Cycles a sender saw s_ready low
   int   ready_mode   = 1;    // 0 ready, 1 stalled, 2 random half, 3 random quarter
   int   seed         = 32'hae2972e6;
   bit   timed_out    = 1'b0; // A wait gave up, run ends early

   always #2 axi_aclk = ~axi_aclk;

   input_arbiter uut (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .s_beat     (s_beat),
      .s_valid    (s_valid),
      .s_ready    (s_ready),
      .m_beat     (m_beat),
      .m_valid    (m_valid),
      .m_ready    (m_ready),
      .pkt_count  (pkt_count)
   );

   arbiter_checker chk (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .s_beat      (s_beat),
      .s_valid     (s_valid),
      .s_ready     (s_ready),
      .m_beat      (m_beat),
      .m_valid     (m_valid),
      .m_ready     (m_ready),
      .pkt_count   (pkt_count),
      .rr_check    (rr_check),
      .count_check (count_check),
      .outstanding (outstanding),
      .error_count (error_count),
      .check_count (check_count)
   );

   // Sink back-pressure, 1 ns after the edge like all stimulus
   always @(posedge axi_aclk) begin
      #1;
      case (ready_mode)
         0:       m_ready = 1'b1;
         2:       m_ready = (($random(seed) & 1) == 1);
         3:       m_ready = (($random(seed) & 3) == 0);   // Mostly stalled
         default: m_ready = 1'b0;
      endcase
   end

   task automatic next_cycle();
      @(posedge axi_aclk);
      #1;
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout while waiting for %s", what);
      timed_out = 1'b1;
      tb_errors++;
   endtask

   // Mode change lands between edges, picked up at the next edge
   task automatic set_ready_mode(input int mode);
      @(negedge axi_aclk);
      ready_mode = mode;
   endtask

   // One packet on one port, each beat held until accepted
   task automatic send_packet(input queue_idx_t port, input int len, input int seq);
      int wait_cnt;
      for (int b = 0; b < len && !timed_out; b++) begin
         s_beat[port].tdata = {6'h30, port, 24'(seq), 32'(b)};   // Port tag and beat index
         s_beat[port].tstrb = (b == len - 1) ? ({strb_width{1'b1}} >> len) : '1;
         s_beat[port].tuser = {port, 14'(seq)};
         s_beat[port].tlast = (b == len - 1);
         s_valid[port]      = 1'b1;
         wait_cnt           = 0;
         while (!s_ready[port] && !timed_out) begin   // Queue near full
            stall_cycles++;
            wait_cnt++;
            if (wait_cnt > 200) begin
               report_timeout($sformatf("s_ready on port %0d", port));
            end else begin
               next_cycle();
            end
         end
         next_cycle();   // Accepted on this edge
      end
      s_valid[port] = 1'b0;
   endtask

   task automatic wait_drained();
      int cycles;
      cycles = 0;
      while (outstanding != 0 && !timed_out) begin
         cycles++;
         if (cycles > 500) begin
            report_timeout("the output stream to drain");
         end else begin
            next_cycle();
         end
      end
      repeat (2) next_cycle();   // Counters settle one edge after the last beat
   endtask

   initial begin
      int seq;
      seq         = 0;
      axi_resetn  = 1'b0;
      s_beat      = '0;
      s_valid     = '0;
      rr_check    = 1'b0;
      count_check = 1'b0;
      repeat (4) @(posedge axi_aclk);
      #1;
      axi_resetn = 1'b1;
      next_cycle();

      for (int ph = 0; ph < 3 && !timed_out; ph++) begin
         case (ph)
            0:       set_ready_mode(0);
            1:       set_ready_mode(1);   // Hold output while all ports load
            default: set_ready_mode(3);
         endcase
         next_cycle();
         for (int r = 0; r < num_rows && !timed_out; r++) begin
            if (rows[r].phase == 2'(ph)) begin
               send_packet(rows[r].port, int'(rows[r].len), seq);
               seq++;
            end
         end
         if (ph == 1) begin
            rr_check = 1'b1;
            set_ready_mode(2);
            next_cycle();
         end
         wait_drained();
         rr_check    = 1'b0;
         count_check = 1'b1;
         next_cycle();
         count_check = 1'b0;
      end

      if (stall_cycles == 0 && !timed_out) begin
         tb_errors++;
         $display("Burst phase never stalled a sender, back-pressure not exercised");
      end

      $display("checks %0d  errors %0d  tb errors %0d", check_count, error_count, tb_errors);
      if (error_count == 0 && tb_errors == 0 && check_count > 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
logic/input_arbiter_pkg.sv
logic/fallthrough_fifo.sv
logic/arbiter_fsm.sv
logic/pkt_counter.sv
logic/input_arbiter.sv
verification/arbiter_checker.sv
verification/input_arbiter_tb.sv
